// ==== hdl/stack_cpu_pkg.sv ====
package stack_cpu_pkg;

  localparam int WORD_W     = 16;
  localparam int DSTK_DEPTH = 16;
  localparam int CSTK_DEPTH = 8;

  typedef enum logic [1:0] {
    SRC_STK0 = 2'h0,
    SRC_FP   = 2'h1,
    SRC_IP   = 2'h2,
    SRC_CSTK = 2'h3
  } src_a_e;

  // Register-form ALU instructions carry these codes in insn[5:0]
  typedef enum logic [5:0] {
    ALU_ADD   = 6'h00,
    ALU_SUB   = 6'h01,
    ALU_AND   = 6'h02,
    ALU_OR    = 6'h03,
    ALU_XOR   = 6'h04,
    ALU_SHL   = 6'h05,
    ALU_SHR   = 6'h06,
    ALU_A     = 6'h07,
    ALU_B     = 6'h08,
    ALU_ADDZ  = 6'h09,
    ALU_ADDNZ = 6'h0a
  } alu_op_e;

  typedef enum logic [1:0] {
    PH_FETCH  = 2'h0,
    PH_DECODE = 2'h1,
    PH_EXEC   = 2'h2,
    PH_LOAD   = 2'h3
  } phase_e;

  typedef struct packed {
    logic              imm;
    logic              sign;
    logic [WORD_W-1:0] imm_mask;
    src_a_e            src_a;
    alu_op_e           alu_sel;
    logic              wr_stk1;
    logic              pop;
    logic              push;
    logic              load_stk;
    logic              load_fp;
    logic              load_ip;
    logic              cpop;
    logic              cpush;
    logic              byt;
    logic              rd_mem;
    logic              wr_mem;
  } ctrl_t;

endpackage

// ==== hdl/insn_decoder.sv ====
`timescale 1ns/1ps

module insn_decoder (
  input  logic [stack_cpu_pkg::WORD_W-1:0] insn,
  output stack_cpu_pkg::ctrl_t             ctrl
);
  import stack_cpu_pkg::*;

  logic [3:0] op;

  assign op = insn[15:12];

  always_comb
  begin
    ctrl.imm     = (op != 4'h7);
    ctrl.wr_stk1 = (op == 4'h7) & insn[3];

    priority casez (op)
      4'b000?:         ctrl.sign = insn[11];
      4'b001?, 4'b0100: ctrl.sign = insn[9];
      default:         ctrl.sign = 1'b0;
    endcase

    priority casez (op)
      4'b1???: ctrl.imm_mask = 16'h7fff;
      4'b000?: ctrl.imm_mask = 16'h0ffe;
      4'b0100: ctrl.imm_mask = 16'h03fe;
      default: ctrl.imm_mask = 16'h03ff;
    endcase

    priority casez (insn)
      16'b000?_????_????_????: ctrl.src_a = SRC_IP;  // JMP, CALL, JZ, JNZ
      16'b001?_????_????_????,
      16'b010?_????_????_????: ctrl.src_a = src_a_e'(insn[11:10]);
      16'b0110_????_????_????: ctrl.src_a = SRC_FP;  // ADD FP
      16'b0111_1???_????_00?0: ctrl.src_a = SRC_CSTK; // RET, CPOP FP
      16'b0111_1???_????_0011: ctrl.src_a = SRC_FP;  // CPUSH FP
      default:                 ctrl.src_a = SRC_STK0;
    endcase

    priority casez (insn)
      16'b1???_????_????_????: ctrl.alu_sel = ALU_B;  // PUSH imm
      16'b0001_????_????_???0: ctrl.alu_sel = ALU_ADDZ;
      16'b0001_????_????_???1: ctrl.alu_sel = ALU_ADDNZ;
      16'b001?_00??_????_????,
      16'b010?_00??_????_????: ctrl.alu_sel = ALU_B;  // No base register
      16'b0111_0???_????_????: ctrl.alu_sel = alu_op_e'(insn[5:0]);
      16'b0111_1???_????_????: ctrl.alu_sel = ALU_A;
      default:                 ctrl.alu_sel = ALU_ADD;
    endcase

    priority casez (insn)
      16'b0010_????_????_????: ctrl.rd_mem = 1'b1; // LD.1
      16'b0100_????_????_???0: ctrl.rd_mem = 1'b1; // LD
      16'b0111_1???_????_10??: ctrl.rd_mem = 1'b1;
      default:                 ctrl.rd_mem = 1'b0;
    endcase

    priority casez (insn)
      16'b0011_????_????_????: ctrl.wr_mem = 1'b1; // ST.1
      16'b0100_????_????_???1: ctrl.wr_mem = 1'b1; // ST
      16'b0111_1???_????_11??: ctrl.wr_mem = 1'b1;
      default:                 ctrl.wr_mem = 1'b0;
    endcase

    priority casez (insn)
      16'b0001_????_????_????: ctrl.pop = 1'b1;
      16'b0011_????_????_????: ctrl.pop = 1'b1;
      16'b0100_????_????_???1: ctrl.pop = 1'b1;
      16'b0111_0???_?1??_????: ctrl.pop = 1'b1; // ALU with pop bit
      16'b0111_1???_????_?1??: ctrl.pop = 1'b1;
      default:                 ctrl.pop = 1'b0;
    endcase

    priority casez (insn)
      16'b1???_????_????_????: ctrl.push = 1'b1;
      16'b0010_????_????_????: ctrl.push = 1'b1;
      16'b0100_????_????_???0: ctrl.push = 1'b1;
      16'b0101_????_????_????: ctrl.push = 1'b1;
      16'b0111_????_1???_????: ctrl.push = 1'b1; // ALU with push bit
      default:                 ctrl.push = 1'b0;
    endcase

    priority casez (insn)
      16'b0111_0???_????_????: ctrl.load_stk = 1'b1;
      16'b0111_1???_????_1?0?: ctrl.load_stk = 1'b1;
      default:                 ctrl.load_stk = ctrl.push;
    endcase

    priority casez (insn)
      16'b0110_????_????_????: ctrl.load_fp = 1'b1;
      16'b0111_1???_????_0010: ctrl.load_fp = 1'b1;
      default:                 ctrl.load_fp = 1'b0;
    endcase

    priority casez (insn)
      16'b000?_????_????_????: ctrl.load_ip = 1'b1;
      16'b0111_1???_????_0000: ctrl.load_ip = 1'b1; // RET
      default:                 ctrl.load_ip = 1'b0;
    endcase

    priority casez (insn)
      16'b0111_1???_????_00?0: ctrl.cpop = 1'b1;
      default:                 ctrl.cpop = 1'b0;
    endcase

    priority casez (insn)
      16'b0000_????_????_???1: ctrl.cpush = 1'b1; // CALL
      16'b0111_1???_????_0011: ctrl.cpush = 1'b1;
      default:                 ctrl.cpush = 1'b0;
    endcase

    priority casez (insn)
      16'b001?_????_????_????: ctrl.byt = 1'b1;
      16'b0111_????_????_???1: ctrl.byt = 1'b1;
      default:                 ctrl.byt = 1'b0;
    endcase
  end

endmodule

// ==== hdl/alu.sv ====
`timescale 1ns/1ps

module alu (
  input  logic [stack_cpu_pkg::WORD_W-1:0] operand_a,
  input  logic [stack_cpu_pkg::WORD_W-1:0] operand_b,
  input  stack_cpu_pkg::alu_op_e           alu_sel,
  input  logic                             top_zero,
  output logic [stack_cpu_pkg::WORD_W-1:0] result
);
  import stack_cpu_pkg::*;

  logic [WORD_W-1:0]         sum;
  logic [$clog2(WORD_W)-1:0] shamt;

  assign sum   = operand_a + operand_b;
  assign shamt = operand_b[$clog2(WORD_W)-1:0];

  always_comb
  begin
    case (alu_sel)
      ALU_ADD:   result = sum;
      ALU_SUB:   result = operand_a - operand_b;
      ALU_AND:   result = operand_a & operand_b;
      ALU_OR:    result = operand_a | operand_b;
      ALU_XOR:   result = operand_a ^ operand_b;
      ALU_SHL:   result = operand_a << shamt;
      ALU_SHR:   result = operand_a >> shamt;
      ALU_A:     result = operand_a;
      ALU_B:     result = operand_b;
      ALU_ADDZ:  result = top_zero ? sum : operand_a; // Taken jump or next ip
      ALU_ADDNZ: result = top_zero ? operand_a : sum;
      default:   result = '0;
    endcase
  end

endmodule

// ==== hdl/hw_stack.sv ====
`timescale 1ns/1ps

module hw_stack #(
  parameter int DEPTH = stack_cpu_pkg::DSTK_DEPTH
) (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             push,
  input  logic                             pop,
  input  logic                             load_top,
  input  logic                             wr_second,
  input  logic [stack_cpu_pkg::WORD_W-1:0] top_in,
  output logic [stack_cpu_pkg::WORD_W-1:0] top,
  output logic [stack_cpu_pkg::WORD_W-1:0] second,
  input  logic                             en
);
  import stack_cpu_pkg::*;

  logic [WORD_W-1:0]        mem [DEPTH];
  logic [$clog2(DEPTH)-1:0] ptr;
  logic [$clog2(DEPTH)-1:0] ptr_nx;

  assign top    = mem[ptr];
  assign second = mem[ptr - 1'b1];

  always_comb
  begin
    ptr_nx = ptr;
    if (push && !pop)
      ptr_nx = ptr + 1'b1; // Wraps at DEPTH
    else if (pop && !push)
      ptr_nx = ptr - 1'b1;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      ptr <= '0;
    else if (en)
      ptr <= ptr_nx;
  end

  always_ff @(posedge clk)
  begin
    if (en && (push || load_top))
      mem[ptr_nx] <= top_in;
    if (en && wr_second)
      mem[ptr_nx - 1'b1] <= top_in; // Entry under the new top
  end

endmodule

// ==== hdl/cpu_regs.sv ====
`timescale 1ns/1ps

module cpu_regs (
  input  logic                             clk,
  input  logic                             rst_n,
  input  stack_cpu_pkg::ctrl_t             ctrl,
  input  logic                             insn_load,
  input  logic [stack_cpu_pkg::WORD_W-1:0] insn_in,
  input  logic                             exec_en,
  input  logic [stack_cpu_pkg::WORD_W-1:0] result,
  input  logic [stack_cpu_pkg::WORD_W-1:0] stk_top,
  input  logic [stack_cpu_pkg::WORD_W-1:0] stk_second,
  input  logic [stack_cpu_pkg::WORD_W-1:0] cstk_top,
  output logic [stack_cpu_pkg::WORD_W-1:0] insn,
  output logic [stack_cpu_pkg::WORD_W-1:0] ip,
  output logic [stack_cpu_pkg::WORD_W-1:0] operand_a,
  output logic [stack_cpu_pkg::WORD_W-1:0] operand_b
);
  import stack_cpu_pkg::*;

  logic [WORD_W-1:0] fp;
  logic [WORD_W-1:0] imm_val;
  logic [WORD_W-1:0] sign_fill;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ip <= '0;
      fp <= '0;
    end
    else
    begin
      if (insn_load)
        ip <= ip + 1'b1; // Jumps are relative to the next word
      else if (exec_en && ctrl.load_ip)
        ip <= result;
      if (exec_en && ctrl.load_fp)
        fp <= result;
    end
  end

  always_ff @(posedge clk)
  begin
    if (insn_load)
      insn <= insn_in;
  end

  // Bits above the field, set when the sign bit is
  assign sign_fill = {WORD_W{ctrl.sign}} & ~(ctrl.imm_mask | WORD_W'(1));
  assign imm_val   = (insn & ctrl.imm_mask) | sign_fill;
  assign operand_b = ctrl.imm ? imm_val : stk_second;

  always_comb
  begin
    case (ctrl.src_a)
      SRC_STK0: operand_a = stk_top;
      SRC_FP:   operand_a = fp;
      SRC_IP:   operand_a = ip;
      SRC_CSTK: operand_a = cstk_top;
      default:  operand_a = stk_top;
    endcase
  end

endmodule

// ==== hdl/cpu_control.sv ====
`timescale 1ns/1ps

module cpu_control (
  input  logic                             clk,
  input  logic                             rst_n,
  input  stack_cpu_pkg::ctrl_t             ctrl,
  input  logic [stack_cpu_pkg::WORD_W-1:0] ip,
  input  logic [stack_cpu_pkg::WORD_W-1:0] result,
  input  logic [stack_cpu_pkg::WORD_W-1:0] stk_top,
  input  logic [stack_cpu_pkg::WORD_W-1:0] stk_second,
  output logic                             mem_rd,
  output logic                             mem_wr,
  output logic                             mem_byte,
  output logic [stack_cpu_pkg::WORD_W-1:0] mem_addr,
  output logic [stack_cpu_pkg::WORD_W-1:0] mem_wdata,
  output logic                             insn_load,
  output logic                             exec_en,
  output logic                             load_en
);
  import stack_cpu_pkg::*;

  phase_e phase;
  phase_e phase_nx;
  logic   run;

  always_comb
  begin
    case (phase)
      PH_FETCH:  phase_nx = run ? PH_DECODE : PH_FETCH; // Hold until out of reset
      PH_DECODE: phase_nx = PH_EXEC;
      PH_EXEC:   phase_nx = ctrl.rd_mem ? PH_LOAD : PH_FETCH;
      default:   phase_nx = PH_FETCH;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      phase <= PH_FETCH;
      run   <= 1'b0;
    end
    else
    begin
      phase <= phase_nx;
      run   <= 1'b1;
    end
  end

  assign insn_load = (phase == PH_DECODE);
  assign exec_en   = (phase == PH_EXEC) & ~ctrl.rd_mem; // Loads update in PH_LOAD
  assign load_en   = (phase == PH_LOAD);

  assign mem_rd    = ((phase == PH_FETCH) & run) | ((phase == PH_EXEC) & ctrl.rd_mem);
  assign mem_wr    = (phase == PH_EXEC) & ctrl.wr_mem;
  assign mem_byte  = (phase == PH_EXEC) & ctrl.byt & (ctrl.rd_mem | ctrl.wr_mem);
  assign mem_addr  = (phase == PH_FETCH) ? ip : result;
  assign mem_wdata = ctrl.imm ? stk_top : stk_second; // Register form stores NOS

endmodule

// ==== hdl/stack_cpu.sv ====
`timescale 1ns/1ps

module stack_cpu (
  input  logic                             clk,
  input  logic                             rst_n,
  output logic [stack_cpu_pkg::WORD_W-1:0] mem_addr,
  output logic                             mem_rd,
  output logic                             mem_wr,
  output logic                             mem_byte,
  output logic [stack_cpu_pkg::WORD_W-1:0] mem_wdata,
  input  logic [stack_cpu_pkg::WORD_W-1:0] mem_rdata
);
  import stack_cpu_pkg::*;

  ctrl_t             ctrl;
  logic [WORD_W-1:0] insn;
  logic [WORD_W-1:0] ip;
  logic [WORD_W-1:0] operand_a;
  logic [WORD_W-1:0] operand_b;
  logic [WORD_W-1:0] result;
  logic [WORD_W-1:0] stk_top;
  logic [WORD_W-1:0] stk_second;
  logic [WORD_W-1:0] cstk_top;
  logic [WORD_W-1:0] dstk_in;
  logic              insn_load;
  logic              exec_en;
  logic              load_en;
  logic              dstk_en;
  logic              top_zero;

  assign dstk_in  = load_en ? mem_rdata : result; // Load data lands on the stack
  assign dstk_en  = exec_en | load_en;
  assign top_zero = (stk_top == '0);

  insn_decoder u_dec (
    .insn (insn),
    .ctrl (ctrl)
  );

  alu u_alu (
    .operand_a (operand_a),
    .operand_b (operand_b),
    .alu_sel   (ctrl.alu_sel),
    .top_zero  (top_zero),
    .result    (result)
  );

  hw_stack #(.DEPTH(DSTK_DEPTH)) u_dstk (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (ctrl.push),
    .pop       (ctrl.pop),
    .load_top  (ctrl.load_stk),
    .wr_second (ctrl.wr_stk1),
    .top_in    (dstk_in),
    .top       (stk_top),
    .second    (stk_second),
    .en        (dstk_en)
  );

  // Return addresses and saved fp both arrive through operand A
  hw_stack #(.DEPTH(CSTK_DEPTH)) u_cstk (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (ctrl.cpush),
    .pop       (ctrl.cpop),
    .load_top  (1'b0),
    .wr_second (1'b0),
    .top_in    (operand_a),
    .top       (cstk_top),
    .second    (),
    .en        (exec_en)
  );

  cpu_regs u_regs (
    .clk        (clk),
    .rst_n      (rst_n),
    .ctrl       (ctrl),
    .insn_load  (insn_load),
    .insn_in    (mem_rdata),
    .exec_en    (exec_en),
    .result     (result),
    .stk_top    (stk_top),
    .stk_second (stk_second),
    .cstk_top   (cstk_top),
    .insn       (insn),
    .ip         (ip),
    .operand_a  (operand_a),
    .operand_b  (operand_b)
  );

  cpu_control u_ctl (
    .clk        (clk),
    .rst_n      (rst_n),
    .ctrl       (ctrl),
    .ip         (ip),
    .result     (result),
    .stk_top    (stk_top),
    .stk_second (stk_second),
    .mem_rd     (mem_rd),
    .mem_wr     (mem_wr),
    .mem_byte   (mem_byte),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .insn_load  (insn_load),
    .exec_en    (exec_en),
    .load_en    (load_en)
  );

endmodule

// ==== test/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
  output logic clk,
  output logic rst_n
);

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk; // 10 ns period
  end

  initial
  begin
    rst_n <= 1'b0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

// ==== test/tb_stack_cpu.sv ====
`timescale 1ns/1ps

module tb_stack_cpu;
  import stack_cpu_pkg::*;

  localparam int MEM_WORDS   = 256;
  localparam int STIM_WORDS  = 512;
  localparam int TRACE_BASE  = 256; // Expected writes follow the program image
  localparam int MAX_WRITES  = (STIM_WORDS - TRACE_BASE) / 3;
  localparam int RESET_LIMIT = 20;
  localparam int WRITE_LIMIT = 100;
  localparam logic [WORD_W-1:0] TRACE_END = 16'hffff;

  logic              clk;
  logic              rst_n;
  logic [WORD_W-1:0] mem_addr;
  logic              mem_rd;
  logic              mem_wr;
  logic              mem_byte;
  logic [WORD_W-1:0] mem_wdata;
  logic [WORD_W-1:0] mem_rdata;

  logic [WORD_W-1:0] stim [STIM_WORDS];
  logic [WORD_W-1:0] mem [MEM_WORDS];

  tb_clock u_clk (
    .clk   (clk),
    .rst_n (rst_n)
  );

  stack_cpu dut0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .mem_addr  (mem_addr),
    .mem_rd    (mem_rd),
    .mem_wr    (mem_wr),
    .mem_byte  (mem_byte),
    .mem_wdata (mem_wdata),
    .mem_rdata (mem_rdata)
  );

  task automatic stop_with_failure();
    $display("=== FAIL ===");
    $fatal(1, "Stopped at the first error");
  endtask

  // Memory model, reads answered one cycle later
  initial
  begin
    int i;
    mem_rdata <= '0;
    for (i = 0; i < STIM_WORDS; i++)
      stim[9'(i)] = 16'h5a00 ^ WORD_W'(i);
    $readmemh("test/stack_cpu_stimulus.mem", stim);
    for (i = 0; i < MEM_WORDS; i++)
      mem[8'(i)] = stim[9'(i)];
    forever
    begin
      @(posedge clk);
      if (mem_rd)
        mem_rdata <= mem_byte ? {8'h00, mem[mem_addr[7:0]][7:0]} : mem[mem_addr[7:0]];
      if (mem_wr && mem_byte)
        mem[mem_addr[7:0]][7:0] = mem_wdata[7:0]; // High byte kept
      else if (mem_wr)
        mem[mem_addr[7:0]] = mem_wdata;
    end
  end

  initial
  begin
    int                cycles;
    int                k;
    logic [8:0]        tix;
    logic [WORD_W-1:0] exp_addr;
    logic [WORD_W-1:0] exp_data;
    logic              exp_byte;

    cycles = 0;
    do
    begin
      @(negedge clk);
      assert (!mem_rd && !mem_wr && !mem_byte) else
      begin
        $display("CHECK FAILED at %0t: bus strobe active in or right after reset", $time);
        stop_with_failure();
      end
      cycles++;
      if (cycles > RESET_LIMIT)
      begin
        $display("Timeout: reset was never released");
        stop_with_failure();
      end
    end while (!rst_n);

    cycles = 0;
    while (!mem_rd)
    begin
      @(negedge clk);
      cycles++;
      if (cycles > RESET_LIMIT)
      begin
        $display("Timeout: no instruction fetch after reset");
        stop_with_failure();
      end
    end
    assert (mem_addr == '0 && !mem_wr) else
    begin
      $display("CHECK FAILED at %0t: first fetch at %h, expected 0000", $time, mem_addr);
      stop_with_failure();
    end

    k   = 0;
    tix = 9'(TRACE_BASE);
    while (k < MAX_WRITES && stim[tix] != TRACE_END)
    begin
      exp_addr = stim[tix];
      exp_data = stim[tix + 9'd1];
      exp_byte = (stim[tix + 9'd2] != '0);
      cycles   = 0;
      do
      begin
        @(negedge clk);
        assert (!(mem_rd && mem_wr)) else
        begin
          $display("CHECK FAILED at %0t: mem_rd and mem_wr high together", $time);
          stop_with_failure();
        end
        cycles++;
        if (cycles > WRITE_LIMIT)
        begin
          $display("Timeout: expected write %0d to address %h never happened", k, exp_addr);
          stop_with_failure();
        end
      end while (!mem_wr);

      assert (mem_addr == exp_addr && mem_byte == exp_byte && mem_wdata == exp_data) else
      begin
        $display("CHECK FAILED at %0t: write %0d got addr %h data %h byte %b",
                 $time, k, mem_addr, mem_wdata, mem_byte);
        $display("  expected addr %h data %h byte %b", exp_addr, exp_data, exp_byte);
        stop_with_failure();
      end
      k++;
      tix = tix + 9'd3;
    end

    if (k > 0)
    begin
      $display("%0d memory writes matched", k);
      $display("=== PASS ===");
      $finish;
    end
    else
    begin
      $display("No expected writes found in the stimulus file");
      stop_with_failure();
    end
  end

endmodule

// ==== test/stack_cpu_stimulus.mem ====
// Words 000-0ff: program image and data, eight words per line
// Words 100 on: expected writes as address, data, byte flag; ffff ffff ffff ends the list
@000
9234 40a1 ffff 40a3 80f0 8f0f 7040 40a5
8003 8010 7041 40a7 bc3c 8ff0 7042 40a9
bc3c 8ff0 7043 40ab bc3c 8ff0 7044 40ad
8004 8123 7045 40af 8008 fb00 7046 40b1
8000 1002 8e01 40b3 8a01 40b5 8005 1002
8a02 40b7 8005 1003 8e03 40b9 8a03 40bb
8000 1003 8a04 40bd 8c01 40bf 0007 8c03
40c1 0008 0000 0000 0000 8c02 40c3 7800
0000 0000 4080 40c5 2081 30c5 60f0 8055
37f0 8066 47fd 0000 0ffe
@080
beef 5ac3
@100
00a0 1234 0000  00a2 7fff 0000  00a4 0fff 0000  00a6 000d 0000
00a8 0c30 0000  00aa 3ffc 0000  00ac 33cc 0000  00ae 1230 0000
00b0 007b 0000  00b4 0a01 0000  00b6 0a02 0000  00ba 0a03 0000
00bc 0a04 0000  00be 0c01 0000  00c2 0c02 0000  00c0 0c03 0000
00c4 beef 0000  00c5 00c3 0001  00e0 0055 0001  00ec 0066 0000
ffff ffff ffff

// ==== verilog.f ====
hdl/stack_cpu_pkg.sv
hdl/insn_decoder.sv
hdl/alu.sv
hdl/hw_stack.sv
hdl/cpu_regs.sv
hdl/cpu_control.sv
hdl/stack_cpu.sv
test/tb_clock.sv
test/tb_stack_cpu.sv

// ==== Makefile ====
TOP = tb_stack_cpu
OBJ = obj_dir

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f verilog.f

sim:
	verilator --binary --assert --top-module $(TOP) -Mdir $(OBJ) -f verilog.f
	@out="$$(./$(OBJ)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "=== PASS ==="

clean:
	rm -rf $(OBJ)
